// File: project.f
+incdir+rtl
rtl/scrmbl_pkg.sv
rtl/present_enc_round.sv
rtl/present_dec_round.sv
rtl/scrmbl_const_lut.sv
rtl/scrmbl_ctrl.sv
rtl/scrmbl_datapath.sv
rtl/otp_scrmbl.sv
tests/tb_clock_gen.sv
tests/tb_otp_scrmbl.sv

// File: run.sh
#!/usr/bin/env bash
# builds the scrambler testbench with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
SIM_BIN=sim_otp_scrmbl
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_otp_scrmbl \
  -f project.f \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "STATUS: PASS" "$LOG_FILE"; then
  exit 0
fi
echo "pass line not found in $LOG_FILE"
exit 1

// File: tests/tb_otp_scrmbl.sv
// testbench for the PRESENT-128 OTP scrambler covering known vector, round trips, latency and digests
`timescale 1ns/1ps

`include "scrmbl_macros.svh"

module tb_otp_scrmbl;

  localparam int unsigned ClkPeriodNs   = 8;
  localparam int unsigned RspLatency    = 32;
  localparam int unsigned NumRoundTrips = 20;
  localparam int unsigned DigestCmds    = 6;
  // every command of every test including the inserted encrypts
  localparam int unsigned NumOps = 1 + 2 * NumRoundTrips + 4 * DigestCmds + (DigestCmds - 1);
  localparam int unsigned WatchdogCycles = (NumOps + 2) * 40;

  // published PRESENT-128 result for zero key and zero plaintext
  localparam logic [`SCRMBL_BLOCK_W-1:0] KnownCipher = 64'h96db_702a_2e69_00af;

  logic                    clk_i;
  logic                    rst_ni;
  scrmbl_pkg::scrmbl_req_t req_i;
  logic                    valid_i;
  logic                    ready_o;
  scrmbl_pkg::scrmbl_rsp_t rsp_o;

  int unsigned checks    = 0;
  int unsigned errors    = 0;
  logic [31:0] lcg_state = 32'h14c7;

  tb_clock_gen #(
    .PeriodNs  (ClkPeriodNs),
    .RstCycles (3)
  ) u_clock_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  otp_scrmbl dut_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .rsp_o   (rsp_o)
  );

  //////////////////////////////
  // error reporting and random numbers

  task automatic report_mismatch(input string test, input logic [63:0] exp,
                                 input logic [63:0] act);
    errors++;
    $display("Fail %s: expected %h, actual %h", test, exp, act);
  endtask

  task automatic count_failure(input string msg);
    errors++;
    $display("Error: %s", msg);
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // 64 random bits from two generator steps
  task automatic next_block(output logic [`SCRMBL_BLOCK_W-1:0] blk);
    lcg_state  = lcg_next(lcg_state);
    blk[63:32] = lcg_state;
    lcg_state  = lcg_next(lcg_state);
    blk[31:0]  = lcg_state;
  endtask

  // low bits of an LCG repeat quickly so the select takes the top bits
  task automatic pick_sel(output logic [`SCRMBL_SEL_W-1:0] sel);
    lcg_state = lcg_next(lcg_state);
    sel       = lcg_state[31:30];
  endtask

  //////////////////////////////
  // command driver with latency checks

  task automatic send_cmd(input scrmbl_pkg::scrmbl_cmd_e        cmd,
                          input logic [`SCRMBL_SEL_W-1:0]   sel,
                          input logic [`SCRMBL_BLOCK_W-1:0] data,
                          output logic [`SCRMBL_BLOCK_W-1:0] result);
    scrmbl_pkg::scrmbl_req_t req;
    int unsigned             cycles;
    logic                    has_rsp;
    req.cmd  = cmd;
    req.sel  = sel;
    req.data = data;
    has_rsp  = !(cmd inside {scrmbl_pkg::LoadShadow, scrmbl_pkg::DigestInit});
    result   = '0;
    cycles   = 0;
    @(posedge clk_i);
    req_i   <= req;
    valid_i <= 1'b1;
    // request stays up until ready_o is seen ahead of an edge
    @(negedge clk_i);
    while (!ready_o) begin
      @(negedge clk_i);
    end
    // accepting edge
    @(posedge clk_i);
    valid_i <= 1'b0;
    req_i   <= '0;
    if (has_rsp) begin
      do begin
        @(negedge clk_i);
        cycles++;
        if (!rsp_o.valid) begin
          checks++;
          assert (!ready_o) else count_failure("ready_o high while a command was running");
        end
      end while (!rsp_o.valid);
      checks++;
      assert (cycles == RspLatency)
        else report_mismatch($sformatf("latency %s", cmd.name()), 64'(RspLatency), 64'(cycles));
      checks++;
      assert (ready_o) else count_failure("ready_o low in the response cycle");
      result = rsp_o.data;
    end else begin
      // no response expected while the engine stays in idle
      @(negedge clk_i);
      checks++;
      assert (ready_o && !rsp_o.valid)
        else count_failure($sformatf("%s left idle or gave a response", cmd.name()));
    end
  endtask

  task automatic check_known_vector(input string test);
    logic [`SCRMBL_BLOCK_W-1:0] res;
    send_cmd(scrmbl_pkg::Encrypt, '0, '0, res);
    checks++;
    assert (res == KnownCipher) else report_mismatch(test, KnownCipher, res);
  endtask

  // two-block Davies-Meyer digest where mix puts an encrypt after each step
  task automatic digest_blocks(input logic [`SCRMBL_BLOCK_W-1:0] hi0,
                               input logic [`SCRMBL_BLOCK_W-1:0] lo0,
                               input logic [`SCRMBL_BLOCK_W-1:0] hi1,
                               input logic [`SCRMBL_BLOCK_W-1:0] lo1,
                               input logic                       mix,
                               output logic [`SCRMBL_BLOCK_W-1:0] digest);
    logic [`SCRMBL_BLOCK_W-1:0] res;
    send_cmd(scrmbl_pkg::DigestInit, '0, '0, res);
    if (mix) check_known_vector("digest_interleave_enc");
    send_cmd(scrmbl_pkg::LoadShadow, '0, lo0, res);
    if (mix) check_known_vector("digest_interleave_enc");
    send_cmd(scrmbl_pkg::Digest, '0, hi0, res);
    if (mix) check_known_vector("digest_interleave_enc");
    send_cmd(scrmbl_pkg::LoadShadow, '0, lo1, res);
    if (mix) check_known_vector("digest_interleave_enc");
    send_cmd(scrmbl_pkg::Digest, '0, hi1, res);
    if (mix) check_known_vector("digest_interleave_enc");
    send_cmd(scrmbl_pkg::DigestFinalize, '0, '0, digest);
  endtask

  //////////////////////////////
  // response bus monitor

  // data bus reads zero between responses
  idle_rsp_data_zero: assert property (
    @(negedge clk_i) disable iff (!rst_ni) !rsp_o.valid |-> rsp_o.data == '0
  ) else report_mismatch("idle_rsp_data", '0, rsp_o.data);

  // valid is a single-cycle pulse
  rsp_valid_one_cycle: assert property (
    @(negedge clk_i) disable iff (!rst_ni) rsp_o.valid |=> !rsp_o.valid
  ) else count_failure("rsp_o.valid stayed high for more than one cycle");

  //////////////////////////////
  // test sequence

  initial begin
    logic [`SCRMBL_BLOCK_W-1:0] pt;
    logic [`SCRMBL_BLOCK_W-1:0] ct;
    logic [`SCRMBL_BLOCK_W-1:0] back;
    logic [`SCRMBL_SEL_W-1:0]   sel;
    logic [`SCRMBL_BLOCK_W-1:0] hi0, lo0, hi1, lo1;
    logic [`SCRMBL_BLOCK_W-1:0] dig_ref, dig_mix, dig_flip, dig_again;
    req_i   = '0;
    valid_i = 1'b0;

    // reset state
    wait (rst_ni === 1'b1);
    @(negedge clk_i);
    checks++;
    assert (ready_o) else count_failure("ready_o low after reset");
    checks++;
    assert (!rsp_o.valid) else count_failure("rsp_o.valid high after reset");

    check_known_vector("known_vector");

    // decrypt must undo encrypt under the same key
    for (int i = 0; i < NumRoundTrips; i++) begin
      next_block(pt);
      pick_sel(sel);
      send_cmd(scrmbl_pkg::Encrypt, sel, pt, ct);
      send_cmd(scrmbl_pkg::Decrypt, sel, ct, back);
      checks++;
      assert (back == pt) else report_mismatch($sformatf("round_trip %0d", i), pt, back);
    end

    // digest state survives encrypts in between
    next_block(hi0);
    next_block(lo0);
    next_block(hi1);
    next_block(lo1);
    digest_blocks(hi0, lo0, hi1, lo1, 1'b0, dig_ref);
    digest_blocks(hi0, lo0, hi1, lo1, 1'b1, dig_mix);
    checks++;
    assert (dig_mix == dig_ref) else report_mismatch("digest_interleave", dig_ref, dig_mix);

    // one flipped shadow bit and then the original sequence again
    lcg_state = lcg_next(lcg_state);
    digest_blocks(hi0, lo0, hi1, lo1 ^ (64'h1 << lcg_state[29:24]), 1'b0, dig_flip);
    checks++;
    assert (dig_flip != dig_ref)
      else count_failure("flipping one shadow bit left the final digest unchanged");
    digest_blocks(hi0, lo0, hi1, lo1, 1'b0, dig_again);
    checks++;
    assert (dig_again == dig_ref) else report_mismatch("digest_repeat", dig_ref, dig_again);

    repeat (2) @(posedge clk_i);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog sized from the command count
  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    errors++;
    $display("Error: watchdog expired after %0d cycles, a command never finished",
             WatchdogCycles);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: tests/tb_clock_gen.sv
// testbench clock and power-on reset source for the scrambler
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned PeriodNs  = 8,
  parameter int unsigned RstCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  // free-running clock, half a period per phase
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2) clk_o = ~clk_o;
    end
  end

  // reset held low for the first rising edges, released on an edge
  initial begin
    rst_no = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: rtl/otp_scrmbl.sv
// iterative PRESENT-128 scrambler for the OTP controller, one round per clock
`timescale 1ns/1ps

`include "scrmbl_macros.svh"

module otp_scrmbl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  scrmbl_pkg::scrmbl_req_t req_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  output scrmbl_pkg::scrmbl_rsp_t rsp_o
);

  // controller to datapath
  scrmbl_pkg::data_sel_e      data_sel;
  scrmbl_pkg::key_sel_e       key_sel;
  logic                       data_en;
  logic                       key_en;
  logic                       shadow_load;
  logic                       digest_en;
  logic                       digest_init;
  logic                       rsp_valid;
  logic [`SCRMBL_BLOCK_W-1:0] rsp_data;

  // constants for the selected key set
  logic [`SCRMBL_KEY_W-1:0]   enc_key;
  logic [`SCRMBL_KEY_W-1:0]   dec_key;
  logic [`SCRMBL_KEY_W-1:0]   dig_const;
  logic [`SCRMBL_BLOCK_W-1:0] dig_iv;

  // working state and round results
  scrmbl_pkg::key_state_u     key_state;
  logic [`SCRMBL_BLOCK_W-1:0] data_state;
  logic [`SCRMBL_IDX_W-1:0]   idx_state;
  logic [`SCRMBL_BLOCK_W-1:0] enc_data, dec_data;
  logic [`SCRMBL_KEY_W-1:0]   enc_key_nxt, dec_key_nxt;
  logic [`SCRMBL_IDX_W-1:0]   enc_idx, dec_idx;

  scrmbl_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_i         (req_i.cmd),
    .valid_i       (valid_i),
    .ready_o       (ready_o),
    .rsp_valid_o   (rsp_valid),
    .data_sel_o    (data_sel),
    .key_sel_o     (key_sel),
    .data_en_o     (data_en),
    .key_en_o      (key_en),
    .shadow_load_o (shadow_load),
    .digest_en_o   (digest_en),
    .digest_init_o (digest_init)
  );

  scrmbl_const_lut u_const_lut (
    .sel_i       (req_i.sel),
    .enc_key_o   (enc_key),
    .dec_key_o   (dec_key),
    .dig_const_o (dig_const),
    .dig_iv_o    (dig_iv)
  );

  scrmbl_datapath u_datapath (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .data_i         (req_i.data),
    .data_sel_i     (data_sel),
    .key_sel_i      (key_sel),
    .data_en_i      (data_en),
    .key_en_i       (key_en),
    .shadow_load_i  (shadow_load),
    .digest_en_i    (digest_en),
    .digest_init_i  (digest_init),
    .rsp_valid_i    (rsp_valid),
    .enc_rnd_data_i (enc_data),
    .enc_rnd_key_i  (enc_key_nxt),
    .enc_rnd_idx_i  (enc_idx),
    .dec_rnd_data_i (dec_data),
    .dec_rnd_key_i  (dec_key_nxt),
    .dec_rnd_idx_i  (dec_idx),
    .enc_key_i      (enc_key),
    .dec_key_i      (dec_key),
    .dig_const_i    (dig_const),
    .dig_iv_i       (dig_iv),
    .key_state_o    (key_state),
    .data_state_o   (data_state),
    .idx_state_o    (idx_state),
    .rsp_data_o     (rsp_data)
  );

  // both rounds look at the same working state
  present_enc_round u_enc_round (
    .data_i (data_state),
    .key_i  (key_state.key),
    .idx_i  (idx_state),
    .data_o (enc_data),
    .key_o  (enc_key_nxt),
    .idx_o  (enc_idx)
  );

  present_dec_round u_dec_round (
    .data_i (data_state),
    .key_i  (key_state.key),
    .idx_i  (idx_state),
    .data_o (dec_data),
    .key_o  (dec_key_nxt),
    .idx_o  (dec_idx)
  );

  assign rsp_o.valid = rsp_valid;
  assign rsp_o.data  = rsp_data;

endmodule

// File: rtl/scrmbl_datapath.sv
// scrambler working registers for key, round index, data, shadow and digest state
`timescale 1ns/1ps

`include "scrmbl_macros.svh"

module scrmbl_datapath (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [`SCRMBL_BLOCK_W-1:0] data_i,
  input  scrmbl_pkg::data_sel_e      data_sel_i,
  input  scrmbl_pkg::key_sel_e       key_sel_i,
  input  logic                       data_en_i,
  input  logic                       key_en_i,
  input  logic                       shadow_load_i,
  input  logic                       digest_en_i,
  input  logic                       digest_init_i,
  input  logic                       rsp_valid_i,
  // next values from the round logic
  input  logic [`SCRMBL_BLOCK_W-1:0] enc_rnd_data_i,
  input  logic [`SCRMBL_KEY_W-1:0]   enc_rnd_key_i,
  input  logic [`SCRMBL_IDX_W-1:0]   enc_rnd_idx_i,
  input  logic [`SCRMBL_BLOCK_W-1:0] dec_rnd_data_i,
  input  logic [`SCRMBL_KEY_W-1:0]   dec_rnd_key_i,
  input  logic [`SCRMBL_IDX_W-1:0]   dec_rnd_idx_i,
  // constants for the current select
  input  logic [`SCRMBL_KEY_W-1:0]   enc_key_i,
  input  logic [`SCRMBL_KEY_W-1:0]   dec_key_i,
  input  logic [`SCRMBL_KEY_W-1:0]   dig_const_i,
  input  logic [`SCRMBL_BLOCK_W-1:0] dig_iv_i,
  output scrmbl_pkg::key_state_u     key_state_o,
  output logic [`SCRMBL_BLOCK_W-1:0] data_state_o,
  output logic [`SCRMBL_IDX_W-1:0]   idx_state_o,
  output logic [`SCRMBL_BLOCK_W-1:0] rsp_data_o
);

  scrmbl_pkg::key_state_u     key_state_d, key_state_q;
  logic [`SCRMBL_IDX_W-1:0]   idx_state_d, idx_state_q;
  logic [`SCRMBL_BLOCK_W-1:0] data_state_d, data_state_q;
  logic [`SCRMBL_BLOCK_W-1:0] shadow_q;
  logic [`SCRMBL_BLOCK_W-1:0] digest_state_d, digest_state_q;
  logic [`SCRMBL_BLOCK_W-1:0] enc_xor;

  // Davies-Meyer: cipher output xor chaining value
  assign enc_xor = enc_rnd_data_i ^ digest_state_q;

  //////////////////////////////
  // source muxes

  always_comb begin
    // digest block is the default key source, built in the block view
    key_state_d.blk.hi = data_i;
    key_state_d.blk.lo = shadow_q;
    unique case (key_sel_i)
      scrmbl_pkg::KeyDecOut:   key_state_d.key = dec_rnd_key_i;
      scrmbl_pkg::KeyEncOut:   key_state_d.key = enc_rnd_key_i;
      scrmbl_pkg::KeyDecInit:  key_state_d.key = dec_key_i;
      scrmbl_pkg::KeyEncInit:  key_state_d.key = enc_key_i;
      scrmbl_pkg::KeyDigConst: key_state_d.key = dig_const_i;
      default: ;
    endcase
  end

  // decrypt counts down from 31, everything else up from 1
  always_comb begin
    unique case (key_sel_i)
      scrmbl_pkg::KeyDecOut:  idx_state_d = dec_rnd_idx_i;
      scrmbl_pkg::KeyEncOut:  idx_state_d = enc_rnd_idx_i;
      scrmbl_pkg::KeyDecInit: idx_state_d = `SCRMBL_IDX_W'(`SCRMBL_NUM_ROUNDS);
      default:                idx_state_d = `SCRMBL_IDX_W'(1);
    endcase
  end

  always_comb begin
    unique case (data_sel_i)
      scrmbl_pkg::DataEncOut:   data_state_d = enc_rnd_data_i;
      scrmbl_pkg::DataDecOut:   data_state_d = dec_rnd_data_i;
      scrmbl_pkg::DataDigState: data_state_d = digest_state_q;
      scrmbl_pkg::DataEncXor:   data_state_d = enc_xor;
      default:                  data_state_d = data_i;
    endcase
  end

  // DigestInit restarts the chain from the IV
  assign digest_state_d = digest_init_i ? dig_iv_i : enc_xor;

  //////////////////////////////
  // registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_state_q    <= '0;
      idx_state_q    <= '0;
      data_state_q   <= '0;
      shadow_q       <= '0;
      digest_state_q <= '0;
    end else begin
      // index travels with the key schedule
      if (key_en_i) begin
        key_state_q <= key_state_d;
        idx_state_q <= idx_state_d;
      end
      if (data_en_i) begin
        data_state_q <= data_state_d;
      end
      if (shadow_load_i) begin
        shadow_q <= data_i;
      end
      if (digest_en_i) begin
        digest_state_q <= digest_state_d;
      end
    end
  end

  assign key_state_o  = key_state_q;
  assign data_state_o = data_state_q;
  assign idx_state_o  = idx_state_q;

  // result only shows while the response is valid
  assign rsp_data_o = rsp_valid_i ? data_state_q : '0;

endmodule

// File: rtl/scrmbl_ctrl.sv
// command decoder FSM and round counter that steer the scrambler datapath
`timescale 1ns/1ps

`include "scrmbl_macros.svh"

module scrmbl_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  scrmbl_pkg::scrmbl_cmd_e cmd_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  output logic                    rsp_valid_o,
  output scrmbl_pkg::data_sel_e   data_sel_o,
  output scrmbl_pkg::key_sel_e    key_sel_o,
  output logic                    data_en_o,
  output logic                    key_en_o,
  output logic                    shadow_load_o,
  output logic                    digest_en_o,
  output logic                    digest_init_o
);

  localparam logic [`SCRMBL_IDX_W-1:0] LastCnt = `SCRMBL_IDX_W'(`SCRMBL_NUM_ROUNDS - 1);

  typedef enum logic [1:0] {
    StIdle,
    StDecrypt,
    StEncrypt,
    StDigest
  } state_e;

  state_e                   state_d, state_q;
  logic [`SCRMBL_IDX_W-1:0] cnt_d, cnt_q;
  logic                     valid_d, valid_q;
  logic                     last_rnd;

  assign last_rnd    = (cnt_q == LastCnt);
  assign rsp_valid_o = valid_q;

  //////////////////////////////
  // next state and datapath steering

  always_comb begin
    state_d       = state_q;
    cnt_d         = cnt_q + 1'b1;
    valid_d       = 1'b0;
    ready_o       = 1'b0;
    data_sel_o    = scrmbl_pkg::DataInput;
    key_sel_o     = scrmbl_pkg::KeyDigInput;
    data_en_o     = 1'b0;
    key_en_o      = 1'b0;
    shadow_load_o = 1'b0;
    digest_en_o   = 1'b0;
    digest_init_o = 1'b0;

    unique case (state_q)
      // decode and load the working registers
      StIdle: begin
        ready_o = 1'b1;
        cnt_d   = '0;
        if (valid_i) begin
          unique case (cmd_i)
            scrmbl_pkg::Decrypt: begin
              state_d   = StDecrypt;
              key_sel_o = scrmbl_pkg::KeyDecInit;
              data_en_o = 1'b1;
              key_en_o  = 1'b1;
            end
            scrmbl_pkg::Encrypt: begin
              state_d   = StEncrypt;
              key_sel_o = scrmbl_pkg::KeyEncInit;
              data_en_o = 1'b1;
              key_en_o  = 1'b1;
            end
            // lower half of the next digest block
            scrmbl_pkg::LoadShadow: begin
              shadow_load_o = 1'b1;
            end
            // digest state is encrypted under {data_i, shadow}
            scrmbl_pkg::Digest: begin
              state_d    = StDigest;
              data_sel_o = scrmbl_pkg::DataDigState;
              data_en_o  = 1'b1;
              key_en_o   = 1'b1;
            end
            scrmbl_pkg::DigestInit: begin
              digest_init_o = 1'b1;
              digest_en_o   = 1'b1;
            end
            // same as Digest but keyed by the finalization constant
            scrmbl_pkg::DigestFinalize: begin
              state_d    = StDigest;
              data_sel_o = scrmbl_pkg::DataDigState;
              key_sel_o  = scrmbl_pkg::KeyDigConst;
              data_en_o  = 1'b1;
              key_en_o   = 1'b1;
            end
            default: ;
          endcase
        end
      end

      StDecrypt: begin
        data_sel_o = scrmbl_pkg::DataDecOut;
        key_sel_o  = scrmbl_pkg::KeyDecOut;
        data_en_o  = 1'b1;
        key_en_o   = 1'b1;
        if (last_rnd) begin
          state_d = StIdle;
          valid_d = 1'b1;
        end
      end

      // digest rounds reuse the encryption round
      StEncrypt,
      StDigest: begin
        data_sel_o = scrmbl_pkg::DataEncOut;
        key_sel_o  = scrmbl_pkg::KeyEncOut;
        data_en_o  = 1'b1;
        key_en_o   = 1'b1;
        if (last_rnd) begin
          state_d = StIdle;
          valid_d = 1'b1;
          // Davies-Meyer feed-forward, kept apart from the data state
          if (state_q == StDigest) begin
            data_sel_o  = scrmbl_pkg::DataEncXor;
            digest_en_o = 1'b1;
          end
        end
      end

      // unreachable encodings go back to idle
      default: begin
        state_d = StIdle;
      end
    endcase
  end

  //////////////////////////////
  // state registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      valid_q <= valid_d;
    end
  end

endmodule

// File: rtl/scrmbl_const_lut.sv
// key, decryption key, digest constant and IV lookup for the scrambler
`timescale 1ns/1ps

`include "scrmbl_macros.svh"

module scrmbl_const_lut (
  input  logic [`SCRMBL_SEL_W-1:0]   sel_i,
  output logic [`SCRMBL_KEY_W-1:0]   enc_key_o,
  output logic [`SCRMBL_KEY_W-1:0]   dec_key_o,
  output logic [`SCRMBL_KEY_W-1:0]   dig_const_o,
  output logic [`SCRMBL_BLOCK_W-1:0] dig_iv_o
);

  // table rounded up to a power of two, unused entries read zero
  localparam int unsigned LutSize = 2 ** `SCRMBL_SEL_W;

  typedef logic [LutSize-1:0][`SCRMBL_KEY_W-1:0] key_lut_t;

  localparam logic [`SCRMBL_NUM_KEYS-1:0][`SCRMBL_KEY_W-1:0] Keys = {
    `SCRMBL_KEY3,
    `SCRMBL_KEY2,
    `SCRMBL_KEY1,
    `SCRMBL_KEY0
  };

  // fills the table at elaboration, dec selects the precomputed decrypt keys
  function automatic key_lut_t build_lut(input logic dec);
    key_lut_t lut;
    lut = '0;
    for (int k = 0; k < `SCRMBL_NUM_KEYS; k++) begin
      lut[k] = dec ? scrmbl_pkg::present_dec_key(Keys[k]) : Keys[k];
    end
    return lut;
  endfunction

  localparam key_lut_t EncKeyLut = build_lut(1'b0);
  localparam key_lut_t DecKeyLut = build_lut(1'b1);

  assign enc_key_o = EncKeyLut[sel_i];
  assign dec_key_o = DecKeyLut[sel_i];

  // one digest set only
  assign dig_const_o = `SCRMBL_DIGEST_CONST;
  assign dig_iv_o    = `SCRMBL_DIGEST_IV;

endmodule

// File: rtl/present_dec_round.sv
// one combinational PRESENT-128 decryption round with its inverse key schedule step
`timescale 1ns/1ps

`include "scrmbl_macros.svh"

module present_dec_round (
  input  logic [`SCRMBL_BLOCK_W-1:0] data_i,
  input  logic [`SCRMBL_KEY_W-1:0]   key_i,
  input  logic [`SCRMBL_IDX_W-1:0]   idx_i,
  output logic [`SCRMBL_BLOCK_W-1:0] data_o,
  output logic [`SCRMBL_KEY_W-1:0]   key_o,
  output logic [`SCRMBL_IDX_W-1:0]   idx_o
);

  localparam logic [`SCRMBL_IDX_W-1:0] LastIdx = `SCRMBL_IDX_W'(`SCRMBL_NUM_ROUNDS);

  logic [`SCRMBL_BLOCK_W-1:0] add_key;
  logic [`SCRMBL_BLOCK_W-1:0] perm_out;
  logic [`SCRMBL_BLOCK_W-1:0] sub_out;

  // first decrypt round strips the output whitening key
  assign add_key = (idx_i == LastIdx) ? data_i ^ key_i[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W]
                                      : data_i;

  assign perm_out = scrmbl_pkg::present_perm_inv(add_key);

  // inverse S-box layer
  always_comb begin
    for (int n = 0; n < `SCRMBL_BLOCK_W / 4; n++) begin
      sub_out[4*n +: 4] = scrmbl_pkg::present_sbox_inv(perm_out[4*n +: 4]);
    end
  end

  // step back to the key this round was entered with on encryption
  assign key_o = scrmbl_pkg::present_key_upd_inv(key_i, idx_i);
  assign idx_o = idx_i - 1'b1;

  // remove that round key, leaving the state before the round
  assign data_o = sub_out ^ key_o[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W];

endmodule

// File: rtl/present_enc_round.sv
// one combinational PRESENT-128 encryption round with its key schedule step
`timescale 1ns/1ps

`include "scrmbl_macros.svh"

module present_enc_round (
  input  logic [`SCRMBL_BLOCK_W-1:0] data_i,
  input  logic [`SCRMBL_KEY_W-1:0]   key_i,
  input  logic [`SCRMBL_IDX_W-1:0]   idx_i,
  output logic [`SCRMBL_BLOCK_W-1:0] data_o,
  output logic [`SCRMBL_KEY_W-1:0]   key_o,
  output logic [`SCRMBL_IDX_W-1:0]   idx_o
);

  localparam logic [`SCRMBL_IDX_W-1:0] LastIdx = `SCRMBL_IDX_W'(`SCRMBL_NUM_ROUNDS);

  logic [`SCRMBL_BLOCK_W-1:0] add_key;
  logic [`SCRMBL_BLOCK_W-1:0] sub_out;
  logic [`SCRMBL_BLOCK_W-1:0] perm_out;

  // round key is the top half of the key register
  assign add_key = data_i ^ key_i[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W];

  // sixteen S-boxes side by side
  always_comb begin
    for (int n = 0; n < `SCRMBL_BLOCK_W / 4; n++) begin
      sub_out[4*n +: 4] = scrmbl_pkg::present_sbox(add_key[4*n +: 4]);
    end
  end

  assign perm_out = scrmbl_pkg::present_perm(sub_out);

  // key schedule runs with the current round number
  assign key_o = scrmbl_pkg::present_key_upd(key_i, idx_i);
  assign idx_o = idx_i + 1'b1;

  // round 31 also adds the 32nd round key as output whitening
  assign data_o = (idx_i == LastIdx) ? perm_out ^ key_o[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W]
                                     : perm_out;

endmodule

// File: rtl/scrmbl_pkg.sv
// scrambler command and bus types plus the PRESENT-128 round and key schedule functions

`include "scrmbl_macros.svh"

package scrmbl_pkg;

  //////////////////////////////
  // command and bus types

  typedef enum logic [2:0] {
    Decrypt,
    Encrypt,
    LoadShadow,
    Digest,
    DigestInit,
    DigestFinalize
  } scrmbl_cmd_e;

  // request word, cmd on top
  typedef struct packed {
    scrmbl_cmd_e                 cmd;
    logic [`SCRMBL_SEL_W-1:0]    sel;
    logic [`SCRMBL_BLOCK_W-1:0]  data;
  } scrmbl_req_t;

  // response, data is zero while valid is low
  typedef struct packed {
    logic                        valid;
    logic [`SCRMBL_BLOCK_W-1:0]  data;
  } scrmbl_rsp_t;

  // 128-bit digest block, data input over shadow
  typedef struct packed {
    logic [`SCRMBL_BLOCK_W-1:0]  hi;
    logic [`SCRMBL_BLOCK_W-1:0]  lo;
  } digest_blk_t;

  // key state holds a cipher key or, for digest updates, a message block
  typedef union packed {
    logic [`SCRMBL_KEY_W-1:0]    key;
    digest_blk_t                 blk;
  } key_state_u;

  // data state source
  typedef enum logic [2:0] {
    DataEncOut,
    DataDecOut,
    DataDigState,
    DataEncXor,
    DataInput
  } data_sel_e;

  // key state source
  typedef enum logic [2:0] {
    KeyDecOut,
    KeyEncOut,
    KeyDecInit,
    KeyEncInit,
    KeyDigConst,
    KeyDigInput
  } key_sel_e;

  //////////////////////////////
  // PRESENT building blocks

  // nibble n of each word holds S(n) and S^-1(n)
  localparam logic [15:0][3:0] PresentSbox    = 64'h2174_8FE3_DA09_B65C;
  localparam logic [15:0][3:0] PresentSboxInv = 64'hA970_364B_D21C_8FE5;

  function automatic logic [3:0] present_sbox(input logic [3:0] nib);
    return PresentSbox[nib];
  endfunction

  function automatic logic [3:0] present_sbox_inv(input logic [3:0] nib);
    return PresentSboxInv[nib];
  endfunction

  // bit i moves to 16*i mod 63, bit 63 stays put
  function automatic logic [63:0] present_perm(input logic [63:0] din);
    logic [63:0] dout;
    dout[63] = din[63];
    for (int i = 0; i < 63; i++) begin
      dout[(16 * i) % 63] = din[i];
    end
    return dout;
  endfunction

  function automatic logic [63:0] present_perm_inv(input logic [63:0] din);
    logic [63:0] dout;
    dout[63] = din[63];
    for (int i = 0; i < 63; i++) begin
      dout[i] = din[(16 * i) % 63];
    end
    return dout;
  endfunction

  // forward key schedule step: rotate left 61, two S-boxes on top, counter into 66:62
  function automatic logic [127:0] present_key_upd(input logic [127:0] key,
                                                   input logic [4:0]   idx);
    logic [127:0] k;
    k          = {key[66:0], key[127:67]};
    k[127:124] = present_sbox(k[127:124]);
    k[123:120] = present_sbox(k[123:120]);
    k[66:62]   = k[66:62] ^ idx;
    return k;
  endfunction

  // undoes present_key_upd for the same counter value
  function automatic logic [127:0] present_key_upd_inv(input logic [127:0] key,
                                                       input logic [4:0]   idx);
    logic [127:0] k;
    k          = key;
    k[66:62]   = k[66:62] ^ idx;
    k[127:124] = present_sbox_inv(k[127:124]);
    k[123:120] = present_sbox_inv(k[123:120]);
    return {k[60:0], k[127:61]};
  endfunction

  // decryption starts from the last round key, 31 schedule steps ahead
  function automatic logic [127:0] present_dec_key(input logic [127:0] key);
    logic [127:0] k;
    k = key;
    for (int i = 1; i <= `SCRMBL_NUM_ROUNDS; i++) begin
      k = present_key_upd(k, 5'(i));
    end
    return k;
  endfunction

endpackage

// File: rtl/scrmbl_macros.svh
// scrambler widths, round count and the fixed key, digest constant and IV values

`ifndef SCRMBL_MACROS_SVH
`define SCRMBL_MACROS_SVH

// datapath widths
`define SCRMBL_BLOCK_W 64
`define SCRMBL_KEY_W 128
`define SCRMBL_IDX_W 5
`define SCRMBL_SEL_W 2

// PRESENT-128 runs 31 rounds plus the closing whitening key
`define SCRMBL_NUM_ROUNDS 31

// scrambling keys, picked by the select field
`define SCRMBL_NUM_KEYS 4
// key 0 is all zeros so the published PRESENT vector applies
`define SCRMBL_KEY0 128'h0000_0000_0000_0000_0000_0000_0000_0000
`define SCRMBL_KEY1 128'h7b0e_54c2_91ad_3f68_e2c7_0b59_a4d1_863f
`define SCRMBL_KEY2 128'hc49a_1e7d_58f3_b260_0d8e_7a2c_f1b4_9563
`define SCRMBL_KEY3 128'h2f86_d3b1_6ac0_4e97_b58d_13fa_7c62_e04b

// digest finalization constant, used as the cipher key
`define SCRMBL_DIGEST_CONST 128'h9e37_79b9_7f4a_7c15_f39c_c060_5ced_c834

// digest initialization vector, loaded into the digest state
`define SCRMBL_DIGEST_IV 64'h0c8a_5f13_e6d2_47b9

`endif
